/* logic/lc3b_types.sv */
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_rob_addr;
	typedef logic [3:0] lc3b_opcode;
	typedef logic [2:0] alu_op_t;

	// Opcodes handled by the ALU path
	localparam lc3b_opcode OP_ADD = 4'b0001;
	localparam lc3b_opcode OP_AND = 4'b0101;
	localparam lc3b_opcode OP_NOT = 4'b1001;
	localparam lc3b_opcode OP_SHF = 4'b1101;

	// ALU function codes
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_AND = 3'd1;
	localparam alu_op_t ALU_NOT = 3'd2;
	localparam alu_op_t ALU_LSHF = 3'd3;
	localparam alu_op_t ALU_RSHFL = 3'd4;
	localparam alu_op_t ALU_RSHFA = 3'd5;

	typedef struct packed {
		logic valid;
		lc3b_rob_addr tag;
		lc3b_word data;
	} cdb_t;

	// Register lookup result, tag only meaningful while busy
	typedef struct packed {
		logic busy;
		lc3b_rob_addr tag;
		lc3b_word data;
	} regfile_t;

	typedef struct packed {
		alu_op_t alu_op;
		lc3b_word vj;
		lc3b_word vk;
		logic rdy_j;
		logic rdy_k;
		lc3b_rob_addr qj;
		lc3b_rob_addr qk;
		lc3b_rob_addr dest;
	} rs_entry_t;

	typedef struct packed {
		logic valid;
		lc3b_reg dest;
		lc3b_word value;
	} commit_t;

endpackage

/* logic/regfile_rename.sv */
module regfile_rename import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input lc3b_reg sr1,
	input lc3b_reg sr2,
	input logic rename_en,
	input lc3b_reg rename_reg,
	input lc3b_rob_addr rename_tag,
	input commit_t commit,
	output regfile_t sr1_out,
	output regfile_t sr2_out
);

	lc3b_word data [8];
	lc3b_rob_addr tag [8];
	logic [7:0] busy;

	// ROB entries retire in allocation order, so this tracks the ROB head
	lc3b_rob_addr commit_tag;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
			commit_tag <= '0;
			for (int i = 0; i < 8; i++) begin
				data[i] <= '0;
				tag[i] <= '0;
			end
		end else begin
			if (commit.valid) begin
				data[commit.dest] <= commit.value;
				commit_tag <= commit_tag + 1'b1;
				// Only the latest writer releases the register
				if (tag[commit.dest] == commit_tag) begin
					busy[commit.dest] <= 1'b0;
				end
			end
			// Placed last so a same-cycle rename overrides the release
			if (rename_en) begin
				busy[rename_reg] <= 1'b1;
				tag[rename_reg] <= rename_tag;
			end
		end
	end

	always_comb begin
		sr1_out.busy = busy[sr1];
		sr1_out.tag = tag[sr1];
		sr1_out.data = data[sr1];
	end

	always_comb begin
		sr2_out.busy = busy[sr2];
		sr2_out.tag = tag[sr2];
		sr2_out.data = data[sr2];
	end

endmodule : regfile_rename

/* logic/reorder_buffer.sv */
module reorder_buffer import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input logic alloc_en,
	input lc3b_reg alloc_reg,
	input cdb_t cdb_in,
	input lc3b_rob_addr rd_tag1,
	input lc3b_rob_addr rd_tag2,
	output lc3b_rob_addr tail_tag,
	output logic rob_full,
	output logic rd_done1,
	output logic rd_done2,
	output lc3b_word rd_value1,
	output lc3b_word rd_value2,
	output commit_t commit
);

	localparam int DEPTH = 8;

	lc3b_reg dest [DEPTH];
	lc3b_word value [DEPTH];
	logic [DEPTH-1:0] done;

	lc3b_rob_addr head;
	lc3b_rob_addr tail;
	logic [3:0] count;
	logic retire;

	// Head may leave once its result has been captured
	assign retire = (count != 4'd0) && done[head];
	assign rob_full = (count == 4'(DEPTH));
	assign tail_tag = tail;

	// Operand lookups for issue
	assign rd_done1 = done[rd_tag1];
	assign rd_done2 = done[rd_tag2];
	assign rd_value1 = value[rd_tag1];
	assign rd_value2 = value[rd_tag2];

	always_ff @(posedge clk) begin
		if (alloc_en) begin
			dest[tail] <= alloc_reg;
		end
		if (cdb_in.valid) begin
			value[cdb_in.tag] <= cdb_in.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			commit <= '0;
		end else begin
			commit.valid <= retire;
			if (retire) begin
				commit.dest <= dest[head];
				commit.value <= value[head];
				head <= head + 1'b1;
			end

			if (alloc_en) begin
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end

			// CDB tag always names a live entry, never the one being allocated
			if (cdb_in.valid) begin
				done[cdb_in.tag] <= 1'b1;
			end

			count <= count + 4'(alloc_en) - 4'(retire);
		end
	end

endmodule : reorder_buffer

/* logic/issue_control.sv */
module issue_control import lc3b_types::*; #(
	parameter int ALU_STATIONS = 3
) (
	input lc3b_word instr,
	input logic instr_is_new,
	input regfile_t sr1_in,
	input regfile_t sr2_in,
	input lc3b_rob_addr rob_tail,
	input logic rob_full,
	input logic rob_done1,
	input logic rob_done2,
	input lc3b_word rob_value1,
	input lc3b_word rob_value2,
	input cdb_t cdb_in,
	input logic [ALU_STATIONS-1:0] station_busy,
	output logic stall,
	output lc3b_reg sr1,
	output lc3b_reg sr2,
	output logic rename_en,
	output lc3b_reg rename_reg,
	output lc3b_rob_addr rename_tag,
	output lc3b_rob_addr rob_rd_tag1,
	output lc3b_rob_addr rob_rd_tag2,
	output logic alloc_en,
	output lc3b_reg alloc_reg,
	output logic [ALU_STATIONS-1:0] rs_write,
	output rs_entry_t rs_entry
);

	lc3b_opcode opcode;
	lc3b_reg dr;
	logic legal;
	logic issue;
	logic [ALU_STATIONS-1:0] free_sel;
	regfile_t src1;
	regfile_t src2;

	// Register file first, then a finished ROB entry, then the live CDB
	function automatic regfile_t resolve(
		input regfile_t rf,
		input logic rob_done,
		input lc3b_word rob_value,
		input cdb_t cdb
	);
		regfile_t res;
		res = rf;
		if (rf.busy && rob_done) begin
			res.busy = 1'b0;
			res.data = rob_value;
		end else if (rf.busy && cdb.valid && cdb.tag == rf.tag) begin
			res.busy = 1'b0;
			res.data = cdb.data;
		end
		return res;
	endfunction

	assign opcode = instr[15:12];
	assign dr = instr[11:9];
	assign sr1 = instr[8:6];
	assign sr2 = instr[2:0];

	assign legal = (opcode == OP_ADD) || (opcode == OP_AND) ||
		(opcode == OP_NOT) || (opcode == OP_SHF);

	// Lowest clear bit of the busy vector
	assign free_sel = ~station_busy & (station_busy + 1'b1);

	assign stall = rob_full || (&station_busy);
	assign issue = instr_is_new && !stall && legal;

	assign rename_en = issue;
	assign rename_reg = dr;
	assign rename_tag = rob_tail;
	assign alloc_en = issue;
	assign alloc_reg = dr;
	assign rs_write = issue ? free_sel : '0;

	assign rob_rd_tag1 = sr1_in.tag;
	assign rob_rd_tag2 = sr2_in.tag;

	assign src1 = resolve(sr1_in, rob_done1, rob_value1, cdb_in);
	assign src2 = resolve(sr2_in, rob_done2, rob_value2, cdb_in);

	always_comb begin
		case (opcode)
			OP_AND: rs_entry.alu_op = ALU_AND;
			OP_NOT: rs_entry.alu_op = ALU_NOT;
			OP_SHF: begin
				if (!instr[4]) begin
					rs_entry.alu_op = ALU_LSHF;
				end else if (instr[5]) begin
					rs_entry.alu_op = ALU_RSHFA;
				end else begin
					rs_entry.alu_op = ALU_RSHFL;
				end
			end
			default: rs_entry.alu_op = ALU_ADD;
		endcase

		rs_entry.vj = src1.data;
		rs_entry.rdy_j = !src1.busy;
		rs_entry.qj = src1.tag;

		rs_entry.vk = src2.data;
		rs_entry.rdy_k = !src2.busy;
		rs_entry.qk = src2.tag;

		if (opcode == OP_SHF) begin
			// Shift amount from imm4
			rs_entry.vk = {12'b0, instr[3:0]};
			rs_entry.rdy_k = 1'b1;
			rs_entry.qk = '0;
		end else if (opcode == OP_NOT) begin
			rs_entry.vk = '0;
			rs_entry.rdy_k = 1'b1;
			rs_entry.qk = '0;
		end else if (instr[5]) begin
			// imm5 form of ADD and AND
			rs_entry.vk = {{11{instr[4]}}, instr[4:0]};
			rs_entry.rdy_k = 1'b1;
			rs_entry.qk = '0;
		end

		rs_entry.dest = rob_tail;
	end

endmodule : issue_control

/* logic/alu_res_stations.sv */
module alu_res_stations import lc3b_types::*; #(
	parameter int ALU_STATIONS = 3
) (
	input logic clk,
	input logic rst,
	input logic [ALU_STATIONS-1:0] rs_write,
	input rs_entry_t rs_entry,
	input cdb_t cdb_in,
	output logic [ALU_STATIONS-1:0] station_busy,
	output cdb_t cdb_out
);

	rs_entry_t entry [ALU_STATIONS];
	logic [ALU_STATIONS-1:0] ready;
	logic [ALU_STATIONS-1:0] grant;
	rs_entry_t winner;
	lc3b_word result;

	for (genvar i = 0; i < ALU_STATIONS; i++) begin : gen_ready
		assign ready[i] = station_busy[i] && entry[i].rdy_j && entry[i].rdy_k;
	end

	// Lowest index wins the CDB
	assign grant = ready & ~(ready - 1'b1);

	always_comb begin
		winner = entry[0];
		for (int i = 0; i < ALU_STATIONS; i++) begin
			if (grant[i]) begin
				winner = entry[i];
			end
		end
	end

	always_comb begin
		case (winner.alu_op)
			ALU_AND: result = winner.vj & winner.vk;
			ALU_NOT: result = ~winner.vj;
			ALU_LSHF: result = winner.vj << winner.vk[3:0];
			ALU_RSHFL: result = winner.vj >> winner.vk[3:0];
			ALU_RSHFA: result = lc3b_word'($signed(winner.vj) >>> winner.vk[3:0]);
			default: result = winner.vj + winner.vk;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			station_busy <= '0;
			cdb_out <= '0;
		end else begin
			// Result goes out one cycle after the grant
			cdb_out.valid <= |grant;
			cdb_out.tag <= winner.dest;
			cdb_out.data <= result;

			for (int i = 0; i < ALU_STATIONS; i++) begin
				if (rs_write[i]) begin
					entry[i] <= rs_entry;
					station_busy[i] <= 1'b1;
				end else begin
					if (grant[i]) begin
						station_busy[i] <= 1'b0;
					end
					// Snoop the CDB for waiting operands
					if (cdb_in.valid && !entry[i].rdy_j && entry[i].qj == cdb_in.tag) begin
						entry[i].vj <= cdb_in.data;
						entry[i].rdy_j <= 1'b1;
					end
					if (cdb_in.valid && !entry[i].rdy_k && entry[i].qk == cdb_in.tag) begin
						entry[i].vk <= cdb_in.data;
						entry[i].rdy_k <= 1'b1;
					end
				end
			end
		end
	end

endmodule : alu_res_stations

/* logic/tomasulo_core.sv */
module tomasulo_core import lc3b_types::*; #(
	parameter int ALU_STATIONS = 3
) (
	input logic clk,
	input logic rst,
	input lc3b_word instr,
	input logic instr_is_new,
	output logic stall,
	output commit_t commit
);

	// Issue to register file
	lc3b_reg sr1;
	lc3b_reg sr2;
	regfile_t sr1_val;
	regfile_t sr2_val;
	logic rename_en;
	lc3b_reg rename_reg;
	lc3b_rob_addr rename_tag;

	// Issue to and from ROB
	lc3b_rob_addr rob_rd_tag1;
	lc3b_rob_addr rob_rd_tag2;
	logic alloc_en;
	lc3b_reg alloc_reg;
	lc3b_rob_addr tail_tag;
	logic rob_full;
	logic rd_done1;
	logic rd_done2;
	lc3b_word rd_value1;
	lc3b_word rd_value2;

	// Issue to stations and the CDB loop
	logic [ALU_STATIONS-1:0] station_busy;
	logic [ALU_STATIONS-1:0] rs_write;
	rs_entry_t rs_entry;
	cdb_t cdb;

	regfile_rename regfile_i (
		.clk(clk),
		.rst(rst),
		.sr1(sr1),
		.sr2(sr2),
		.rename_en(rename_en),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag),
		.commit(commit),
		.sr1_out(sr1_val),
		.sr2_out(sr2_val)
	);

	reorder_buffer rob_i (
		.clk(clk),
		.rst(rst),
		.alloc_en(alloc_en),
		.alloc_reg(alloc_reg),
		.cdb_in(cdb),
		.rd_tag1(rob_rd_tag1),
		.rd_tag2(rob_rd_tag2),
		.tail_tag(tail_tag),
		.rob_full(rob_full),
		.rd_done1(rd_done1),
		.rd_done2(rd_done2),
		.rd_value1(rd_value1),
		.rd_value2(rd_value2),
		.commit(commit)
	);

	issue_control #(
		.ALU_STATIONS(ALU_STATIONS)
	) issue_i (
		.instr(instr),
		.instr_is_new(instr_is_new),
		.sr1_in(sr1_val),
		.sr2_in(sr2_val),
		.rob_tail(tail_tag),
		.rob_full(rob_full),
		.rob_done1(rd_done1),
		.rob_done2(rd_done2),
		.rob_value1(rd_value1),
		.rob_value2(rd_value2),
		.cdb_in(cdb),
		.station_busy(station_busy),
		.stall(stall),
		.sr1(sr1),
		.sr2(sr2),
		.rename_en(rename_en),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag),
		.rob_rd_tag1(rob_rd_tag1),
		.rob_rd_tag2(rob_rd_tag2),
		.alloc_en(alloc_en),
		.alloc_reg(alloc_reg),
		.rs_write(rs_write),
		.rs_entry(rs_entry)
	);

	alu_res_stations #(
		.ALU_STATIONS(ALU_STATIONS)
	) stations_i (
		.clk(clk),
		.rst(rst),
		.rs_write(rs_write),
		.rs_entry(rs_entry),
		.cdb_in(cdb),
		.station_busy(station_busy),
		.cdb_out(cdb)
	);

endmodule : tomasulo_core

/* bench/lc3b_ref.svh */
`ifndef LC3B_REF_SVH
`define LC3B_REF_SVH

// Destination field, common to ADD, AND, NOT and SHF
function automatic lc3b_reg ref_dest(input lc3b_word ir);
	return ir[11:9];
endfunction

// imm5 taken as a two's complement value
function automatic lc3b_word sext5(input logic [4:0] imm);
	lc3b_word w;
	w = {11'b0, imm};
	if (imm[4]) begin
		w = w - 16'd32;
	end
	return w;
endfunction

// One bit per step, sign bit copied in from the left
function automatic lc3b_word shift_right_arith(input lc3b_word v, input logic [3:0] amt);
	lc3b_word w;
	w = v;
	for (int i = 0; i < amt; i++) begin
		w = {w[15], w[15:1]};
	end
	return w;
endfunction

// a is the SR1 value, b_reg the SR2 value, both from the register model
function automatic lc3b_word ref_result(input lc3b_word ir, input lc3b_word a,
		input lc3b_word b_reg);
	lc3b_word b;
	lc3b_word res;
	b = ir[5] ? sext5(ir[4:0]) : b_reg;
	case (ir[15:12])
		4'b0001: res = a + b;
		4'b0101: res = a & b;
		4'b1001: res = ~a;
		default: begin
			// SHF, bit 4 picks right, bit 5 picks arithmetic
			if (!ir[4]) begin
				res = a << ir[3:0];
			end else if (!ir[5]) begin
				res = a >> ir[3:0];
			end else begin
				res = shift_right_arith(a, ir[3:0]);
			end
		end
	endcase
	return res;
endfunction

`endif

/* bench/tb_core.sv */
module tb_core import lc3b_types::*; ();

	`include "lc3b_ref.svh"

	localparam int BURST_LEN = 24;
	localparam int RANDOM_LEN = 200;

	logic clk;
	logic rst;
	lc3b_word instr;
	logic instr_is_new;
	logic stall;
	commit_t commit;

	// Bit 16 set offers the word and clear means one idle cycle
	logic [16:0] stim_q [$];
	commit_t expect_q [$];
	commit_t expected;
	lc3b_word ref_regs [8];
	integer seed;
	int accept_count;
	int commit_count;
	int cycle_count;
	int cycle_limit;
	int burst_first;
	int burst_last;
	int burst_stalls;

	tomasulo_core #(
		.ALU_STATIONS(3)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instr_is_new(instr_is_new),
		.stall(stall),
		.commit(commit)
	);

	always #5 clk = ~clk;

	task automatic stop_with_failure();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input lc3b_word got, input lc3b_word exp);
		assert (got === exp) else begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	function automatic lc3b_word op_reg(lc3b_opcode op, lc3b_reg dr, lc3b_reg sa, lc3b_reg sb);
		return {op, dr, sa, 3'b000, sb};
	endfunction

	function automatic lc3b_word op_imm(lc3b_opcode op, lc3b_reg dr, lc3b_reg sa,
			logic [4:0] imm);
		return {op, dr, sa, 1'b1, imm};
	endfunction

	function automatic lc3b_word op_not(lc3b_reg dr, lc3b_reg sa);
		return {OP_NOT, dr, sa, 6'b111111};
	endfunction

	// kind is {arithmetic, right}
	function automatic lc3b_word op_shf(lc3b_reg dr, lc3b_reg sa, logic [1:0] kind,
			logic [3:0] amt);
		return {OP_SHF, dr, sa, kind, amt};
	endfunction

	function automatic lc3b_word random_instr();
		lc3b_word r;
		lc3b_word w;
		r = lc3b_word'($random(seed));
		case (r[15:13])
			3'd0, 3'd1, 3'd2: begin
				w = r[5] ? op_imm(OP_ADD, r[11:9], r[8:6], r[4:0])
					: op_reg(OP_ADD, r[11:9], r[8:6], r[2:0]);
			end
			3'd3, 3'd4: begin
				w = r[5] ? op_imm(OP_AND, r[11:9], r[8:6], r[4:0])
					: op_reg(OP_AND, r[11:9], r[8:6], r[2:0]);
			end
			3'd5: w = op_not(r[11:9], r[8:6]);
			// Kind 2'b10 is not a legal SHF encoding
			default: w = op_shf(r[11:9], r[8:6], {r[5] & r[4], r[4]}, r[3:0]);
		endcase
		return w;
	endfunction

	task automatic add_word(input lc3b_word w);
		stim_q.push_back({1'b1, w});
	endtask

	task automatic add_idle();
		stim_q.push_back(17'd0);
	endtask

	// Reference model advances in program order
	task automatic record_accept(input lc3b_word word);
		lc3b_word res;
		res = ref_result(word, ref_regs[word[8:6]], ref_regs[word[2:0]]);
		ref_regs[ref_dest(word)] = res;
		expect_q.push_back({1'b1, ref_dest(word), res});
		accept_count++;
	endtask

	// Stall only moves on rising edges, so its value at the falling edge holds
	task automatic offer(input lc3b_word word, output int stalls);
		stalls = 0;
		@(negedge clk);
		instr = word;
		instr_is_new = 1'b1;
		while (stall) begin
			stalls++;
			@(negedge clk);
		end
		record_accept(word);
	endtask

	task automatic build_directed();
		// Independent immediates
		add_word(op_imm(OP_ADD, 3'd1, 3'd0, 5'd7));
		add_word(op_imm(OP_ADD, 3'd2, 3'd0, -5'sd16));
		add_word(op_imm(OP_ADD, 3'd3, 3'd0, 5'd15));
		add_word(op_imm(OP_AND, 3'd4, 3'd0, -5'sd1));
		add_word(op_imm(OP_ADD, 3'd5, 3'd0, -5'sd1));
		add_word(op_imm(OP_AND, 3'd6, 3'd7, 5'd9));
		// RAW chains and WAW rewrites of R1
		add_word(op_imm(OP_ADD, 3'd1, 3'd1, 5'd4));
		add_word(op_reg(OP_ADD, 3'd2, 3'd1, 3'd1));
		add_word(op_imm(OP_AND, 3'd3, 3'd2, -5'sd2));
		add_word(op_imm(OP_ADD, 3'd1, 3'd2, -5'sd5));
		add_word(op_reg(OP_ADD, 3'd4, 3'd1, 3'd3));
		add_word(op_reg(OP_AND, 3'd1, 3'd1, 3'd4));
		add_word(op_reg(OP_ADD, 3'd1, 3'd1, 3'd1));
		repeat (6) add_idle();
		add_word(op_reg(OP_ADD, 3'd5, 3'd1, 3'd4));
		// Negative values through every shift kind and NOT
		add_word(op_imm(OP_ADD, 3'd6, 3'd0, -5'sd16));
		add_word(op_shf(3'd6, 3'd6, 2'b00, 4'd11));
		add_word(op_shf(3'd5, 3'd6, 2'b11, 4'd4));
		add_word(op_shf(3'd4, 3'd6, 2'b01, 4'd4));
		add_word(op_not(3'd3, 3'd6));
		add_word(op_shf(3'd2, 3'd3, 2'b11, 4'd15));
		add_word(op_shf(3'd7, 3'd5, 2'b11, 4'd15));
		add_word(op_shf(3'd1, 3'd4, 2'b00, 4'd0));
		add_word(op_not(3'd0, 3'd7));
	endtask

	always @(negedge clk) begin
		if (!rst && commit.valid) begin
			if (expect_q.size() == 0) begin
				$display("A commit arrived with no accepted instruction left to retire");
				stop_with_failure();
			end else begin
				expected = expect_q.pop_front();
				check_value("commit.dest", lc3b_word'(commit.dest),
					lc3b_word'(expected.dest));
				check_value("commit.value", commit.value, expected.value);
				commit_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: commits stopped arriving, %0d of %0d retired",
				commit_count, accept_count);
			stop_with_failure();
		end
	end

	initial begin
		int stalls;
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		instr_is_new = 1'b0;
		seed = 37251;
		accept_count = 0;
		commit_count = 0;
		cycle_count = 0;
		burst_stalls = 0;
		for (int i = 0; i < 8; i++) begin
			ref_regs[i] = '0;
		end

		build_directed();
		// Two interleaved chains issued back to back
		burst_first = stim_q.size();
		for (int i = 0; i < BURST_LEN; i++) begin
			add_word(op_imm(OP_ADD, 3'd1, 3'd1, 5'd3));
			add_word(op_reg(OP_ADD, 3'd2, 3'd2, 3'd1));
		end
		burst_last = stim_q.size() - 1;
		for (int i = 0; i < RANDOM_LEN; i++) begin
			if (($random(seed) & 3) == 0) begin
				add_idle();
			end
			add_word(random_instr());
		end
		cycle_limit = 20 * stim_q.size() + 100;

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("commit.valid", lc3b_word'(commit.valid), 16'h0000);
		check_value("stall", lc3b_word'(stall), 16'h0000);

		for (int i = 0; i < stim_q.size(); i++) begin
			if (stim_q[i][16]) begin
				offer(stim_q[i][15:0], stalls);
				if (i >= burst_first && i <= burst_last) begin
					burst_stalls += stalls;
				end
			end else begin
				@(negedge clk);
				instr_is_new = 1'b0;
			end
		end
		@(negedge clk);
		instr_is_new = 1'b0;

		while (commit_count < accept_count) begin
			@(negedge clk);
		end
		// Extra commits would show up here
		repeat (10) @(negedge clk);

		assert (burst_stalls > 0) else begin
			$display("Stall never rose during the dependent burst");
			stop_with_failure();
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule : tb_core

/* filelist.f */
+incdir+bench
logic/lc3b_types.sv
logic/regfile_rename.sv
logic/reorder_buffer.sv
logic/issue_control.sv
logic/alu_res_stations.sv
logic/tomasulo_core.sv
bench/tb_core.sv
